// File: Bender.yml
package:
  name: id_stage

sources:
  - verilog/rv_isa_pkg.sv
  - verilog/pipe_pkg.sv
  - verilog/instr_decoder.sv
  - verilog/hazard_stall.sv
  - verilog/inflight_tracker.sv
  - verilog/id_stage_top.sv
  - target: test
    files:
      - dv/id_stage_assert.sv
      - dv/id_stage_tb.sv

// File: all.f
verilog/rv_isa_pkg.sv
verilog/pipe_pkg.sv
verilog/instr_decoder.sv
verilog/hazard_stall.sv
verilog/inflight_tracker.sv
verilog/id_stage_top.sv
dv/id_stage_assert.sv
dv/id_stage_tb.sv

// File: dv/id_stage_assert.sv
`default_nettype none

module id_stage_assert
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      fetch_valid,
    input  xlen_t     fetch_pc,
    input  instr_t    fetch_instr,
    input  logic      stall,
    input  logic      issue_valid,
    input  decoded_t  id_dec,
    input  inflight_t ex_entry,
    input  inflight_t mem_entry
);

    int unsigned error_count = 0;

    logic rs1_waits;
    logic rs2_waits;

    // an alu or load result in ex, or a load in mem, is not yet readable.
    assign rs1_waits = id_dec.use_rs1 && (id_dec.rs1 != reg_zero) &&
        ((ex_entry.valid && (ex_entry.dec.writer == wr_alu ||
                             ex_entry.dec.writer == wr_load) &&
          ex_entry.dec.rd == id_dec.rs1) ||
         (mem_entry.valid && mem_entry.dec.writer == wr_load &&
          mem_entry.dec.rd == id_dec.rs1));

    assign rs2_waits = id_dec.use_rs2 && (id_dec.rs2 != reg_zero) &&
        ((ex_entry.valid && (ex_entry.dec.writer == wr_alu ||
                             ex_entry.dec.writer == wr_load) &&
          ex_entry.dec.rd == id_dec.rs2) ||
         (mem_entry.valid && mem_entry.dec.writer == wr_load &&
          mem_entry.dec.rd == id_dec.rs2));

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !stall && !issue_valid)
        else begin
            $error("stall or issue_valid active in reset");
            error_count++;
        end

    a_bubble_after_stall: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> !issue_valid)
        else begin
            $error("instruction issued after a stall cycle");
            error_count++;
        end

    a_bubble_after_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !fetch_valid |=> !issue_valid)
        else begin
            $error("instruction issued after an empty fetch cycle");
            error_count++;
        end

    a_stall_needs_writer: assert property (@(posedge clk) disable iff (!rst_n)
        stall |-> fetch_valid && (rs1_waits || rs2_waits))
        else begin
            $error("stall without a pending writer of a source");
            error_count++;
        end

    a_writer_stalls: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_valid && (rs1_waits || rs2_waits) |-> stall)
        else begin
            $error("pending writer of a source did not stall");
            error_count++;
        end

    // fetch side contract, the held instruction must not change.
    a_fetch_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall |=> fetch_valid && $stable(fetch_pc) && $stable(fetch_instr))
        else begin
            $error("fetch inputs changed during a stall");
            error_count++;
        end

endmodule

bind id_stage_top id_stage_assert u_assert (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_valid (fetch_valid),
    .fetch_pc    (fetch_pc),
    .fetch_instr (fetch_instr),
    .stall       (stall),
    .issue_valid (issue_valid),
    .id_dec      (id_dec),
    .ex_entry    (ex_entry),
    .mem_entry   (mem_entry)
);

`default_nettype wire

// File: dv/id_stage_tb.sv
`default_nettype none

module id_stage_tb
    import rv_isa_pkg::*;
    import pipe_pkg::*;
();

    localparam int unsigned n_directed     = 21;
    localparam int unsigned n_random       = 300;
    // each instruction takes at most one idle, two stall and one issue cycle.
    localparam int unsigned timeout_cycles = (n_directed + n_random) * 4 + 50;

    typedef struct packed {
        xlen_t         pc;
        instr_t        instr;
        writer_class_e writer;
    } issue_rec_t;

    logic        clk;
    logic        rst_n;
    logic        fetch_valid;
    xlen_t       fetch_pc;
    instr_t      fetch_instr;
    logic        stall;
    logic        issue_valid;
    decoded_t    issue;

    issue_rec_t  expected_q[$];
    issue_rec_t  head;
    string       test_name;
    int unsigned cycle_count;
    int unsigned ready_edge[32];
    logic        consumed_prev;
    xlen_t       next_pc;
    logic [31:0] rng_state;

    id_stage_top DUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr),
        .stall       (stall),
        .issue_valid (issue_valid),
        .issue       (issue)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic fail_with(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("mismatch in %s: %s expected 0x%0h actual 0x%0h",
                 test_name, what, expected, actual);
        stop_run();
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // instruction words built from the base encodings.
    function automatic instr_t op_word(input reg_addr_t rd, input reg_addr_t rs1,
                                       input reg_addr_t rs2);
        return {7'b0000000, rs2, rs1, 3'b000, rd, opc_op};
    endfunction

    function automatic instr_t op_imm_word(input reg_addr_t rd, input reg_addr_t rs1,
                                           input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, opc_op_imm};
    endfunction

    // ld rd, 8(rs1).
    function automatic instr_t load_word(input reg_addr_t rd, input reg_addr_t rs1);
        return {12'h008, rs1, 3'b011, rd, opc_load};
    endfunction

    // sd rs2, 8(rs1).
    function automatic instr_t store_word(input reg_addr_t rs2, input reg_addr_t rs1);
        return {7'b0000000, rs2, rs1, 3'b011, 5'b01000, opc_store};
    endfunction

    function automatic instr_t branch_word(input reg_addr_t rs1, input reg_addr_t rs2);
        return {7'b0000000, rs2, rs1, 3'b000, 5'b01000, opc_branch};
    endfunction

    // lui and jal carry raw immediate bits in [31:12].
    function automatic instr_t upper_word(input opcode_t opc, input reg_addr_t rd,
                                          input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    // presents one instruction and holds it until it is consumed.
    // src1 and src2 name the registers the format reads and are x0 when unused.
    task automatic send(input instr_t instr, input reg_addr_t rd_w, input logic is_load,
                        input reg_addr_t src1, input reg_addr_t src2,
                        input int exp_stalls);
        int unsigned   first_edge;
        int unsigned   earliest;
        int unsigned   ready;
        int            model_stalls;
        int            stalls;
        writer_class_e exp_writer;
        // an alu result frees readers two edges after issue and a load three.
        first_edge = cycle_count + 1;
        earliest   = first_edge;
        if (src1 != reg_zero && ready_edge[src1] > earliest) begin
            earliest = ready_edge[src1];
        end
        if (src2 != reg_zero && ready_edge[src2] > earliest) begin
            earliest = ready_edge[src2];
        end
        model_stalls = earliest - first_edge;
        if (rd_w == reg_zero) begin
            exp_writer = wr_none;
        end else if (is_load) begin
            exp_writer = wr_load;
        end else begin
            exp_writer = wr_alu;
        end
        stalls       = 0;
        fetch_valid  = 1'b1;
        fetch_pc     = next_pc;
        fetch_instr  = instr;
        @(negedge clk);
        while (stall) begin
            stalls++;
            @(negedge clk);
        end
        expected_q.push_back('{pc: next_pc, instr: instr, writer: exp_writer});
        assert (stalls == model_stalls)
            else report_mismatch("stall count against writer model", model_stalls, stalls);
        if (exp_stalls >= 0) begin
            assert (stalls == exp_stalls)
                else report_mismatch("stall count", exp_stalls, stalls);
        end
        if (rd_w != reg_zero) begin
            ready = cycle_count + 1 + (is_load ? 3 : 2);
            if (ready > ready_edge[rd_w]) begin
                ready_edge[rd_w] = ready;
            end
        end
        next_pc = next_pc + 4;
        @(posedge clk);
        #1;
    endtask

    task automatic idle(input int unsigned cycles);
        fetch_valid = 1'b0;
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    // registers x0 to x3 only so that hazards come often.
    task automatic random_stream(input int unsigned count);
        logic [31:0] r;
        reg_addr_t   a;
        reg_addr_t   b;
        reg_addr_t   c;
        for (int unsigned i = 0; i < count; i++) begin
            rng_state = xorshift32(rng_state);
            r = rng_state;
            a = {3'b000, r[4:3]};
            b = {3'b000, r[6:5]};
            c = {3'b000, r[8:7]};
            if (r[15:13] == 3'd0) begin
                idle(1);
            end
            case (r[11:9])
                3'd0, 3'd7: send(op_word(a, b, c), a, 1'b0, b, c, -1);
                3'd1:       send(op_imm_word(a, b, 12'h001), a, 1'b0, b, reg_zero, -1);
                3'd2, 3'd3: send(load_word(a, b), a, 1'b1, b, reg_zero, -1);
                3'd4:       send(store_word(c, b), reg_zero, 1'b0, b, c, -1);
                3'd5:       send(branch_word(b, c), reg_zero, 1'b0, b, c, -1);
                default:    send(upper_word(opc_lui, a, r[31:12]), a, 1'b0,
                                 reg_zero, reg_zero, -1);
            endcase
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            fail_with($sformatf("timeout: run did not finish within %0d cycles",
                                timeout_cycles));
        end
    end

    // issue order and bubble checks sampled mid-cycle.
    always @(negedge clk) begin
        if (!rst_n) begin
            assert (!stall && !issue_valid)
                else fail_with("stall or issue_valid high during reset");
            consumed_prev = 1'b0;
        end else begin
            assert (issue_valid == consumed_prev)
                else report_mismatch("issue_valid", consumed_prev, issue_valid);
            if (issue_valid) begin
                if (expected_q.size() == 0) begin
                    fail_with("instruction issued although none was consumed");
                end
                head = expected_q.pop_front();
                assert (issue.pc == head.pc)
                    else report_mismatch("issue.pc", head.pc, issue.pc);
                assert (issue.instr == head.instr)
                    else report_mismatch("issue.instr", head.instr, issue.instr);
                assert (issue.writer == head.writer)
                    else report_mismatch("issue.writer", head.writer, issue.writer);
            end
            consumed_prev = fetch_valid && !stall;
            if (DUT.u_assert.error_count != 0) begin
                fail_with("a bound assertion on the id stage failed");
            end
        end
    end

    initial begin
        rst_n         = 1'b0;
        fetch_valid   = 1'b0;
        fetch_pc      = '0;
        fetch_instr   = '0;
        cycle_count   = 0;
        consumed_prev = 1'b0;
        next_pc       = 64'h0000_0000_0000_1000;
        rng_state     = 32'd96;
        for (int i = 0; i < 32; i++) begin
            ready_edge[i] = 0;
        end

        test_name = "reset";
        repeat (4) @(posedge clk);
        #1;
        rst_n = 1'b1;
        idle(3);

        test_name = "alu_raw";
        send(op_imm_word(5'd5, 5'd0, 12'h001), 5'd5, 1'b0, 5'd0, 5'd0, 0);
        send(op_word(5'd6, 5'd5, 5'd5), 5'd6, 1'b0, 5'd5, 5'd5, 1);
        idle(3);

        test_name = "load_use";
        send(load_word(5'd7, 5'd1), 5'd7, 1'b1, 5'd1, 5'd0, 0);
        send(op_word(5'd8, 5'd7, 5'd0), 5'd8, 1'b0, 5'd7, 5'd0, 2);
        idle(3);

        test_name = "load_gap1";
        send(load_word(5'd7, 5'd1), 5'd7, 1'b1, 5'd1, 5'd0, 0);
        send(op_imm_word(5'd9, 5'd0, 12'h003), 5'd9, 1'b0, 5'd0, 5'd0, 0);
        send(op_word(5'd8, 5'd0, 5'd7), 5'd8, 1'b0, 5'd0, 5'd7, 1);
        idle(3);

        test_name = "load_gap2";
        send(load_word(5'd7, 5'd1), 5'd7, 1'b1, 5'd1, 5'd0, 0);
        send(op_imm_word(5'd9, 5'd0, 12'h003), 5'd9, 1'b0, 5'd0, 5'd0, 0);
        send(op_imm_word(5'd10, 5'd0, 12'h004), 5'd10, 1'b0, 5'd0, 5'd0, 0);
        send(op_word(5'd8, 5'd7, 5'd7), 5'd8, 1'b0, 5'd7, 5'd7, 0);
        idle(3);

        // lui and jal carry x12 in both source field positions.
        test_name = "x0_and_unread_fields";
        send(op_imm_word(5'd0, 5'd1, 12'h005), 5'd0, 1'b0, 5'd1, 5'd0, 0);
        send(op_word(5'd11, 5'd0, 5'd0), 5'd11, 1'b0, 5'd0, 5'd0, 0);
        send(load_word(5'd12, 5'd2), 5'd12, 1'b1, 5'd2, 5'd0, 0);
        send(upper_word(opc_lui, 5'd13, {7'd0, 5'd12, 5'd12, 3'd0}), 5'd13, 1'b0,
             5'd0, 5'd0, 0);
        send(upper_word(opc_jal, 5'd14, {7'd0, 5'd12, 5'd12, 3'd0}), 5'd14, 1'b0,
             5'd0, 5'd0, 0);
        idle(3);

        // the store's immediate bits sit in the rd field as x8.
        test_name = "store_branch";
        send(load_word(5'd15, 5'd2), 5'd15, 1'b1, 5'd2, 5'd0, 0);
        send(store_word(5'd15, 5'd2), 5'd0, 1'b0, 5'd2, 5'd15, 2);
        send(op_imm_word(5'd17, 5'd8, 12'h001), 5'd17, 1'b0, 5'd8, 5'd0, 0);
        send(load_word(5'd16, 5'd2), 5'd16, 1'b1, 5'd2, 5'd0, 0);
        send(branch_word(5'd16, 5'd0), 5'd0, 1'b0, 5'd16, 5'd0, 2);
        idle(3);

        test_name = "random";
        random_stream(n_random);
        idle(4);

        if (expected_q.size() != 0 || DUT.u_assert.error_count != 0) begin
            fail_with("consumed instructions never issued or bound assertions failed");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verilog/hazard_stall.sv
`default_nettype none

module hazard_stall
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic      fetch_valid,
    input  decoded_t  id_dec,
    input  inflight_t ex_entry,
    input  inflight_t mem_entry,
    output logic      stall
);

    logic rs1_blocked;
    logic rs2_blocked;

    // true when the source is read and its value is not yet available.
    // any writer in ex is still computing; a load in mem has not returned.
    function automatic logic src_blocked(
        input logic      used,
        input reg_addr_t src,
        input inflight_t ex,
        input inflight_t mem
    );
        logic ex_hit;
        logic mem_hit;

        ex_hit  = ex.valid && (ex.dec.writer != wr_none) && (ex.dec.rd == src);
        mem_hit = mem.valid && (mem.dec.writer == wr_load) && (mem.dec.rd == src);
        return used && (src != reg_zero) && (ex_hit || mem_hit);
    endfunction

    assign rs1_blocked = src_blocked(id_dec.use_rs1, id_dec.rs1, ex_entry, mem_entry);
    assign rs2_blocked = src_blocked(id_dec.use_rs2, id_dec.rs2, ex_entry, mem_entry);

    // an empty fetch slot has nothing to hold back.
    assign stall = fetch_valid && (rs1_blocked || rs2_blocked);

endmodule

`default_nettype wire

// File: verilog/id_stage_top.sv
`default_nettype none

module id_stage_top
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     fetch_valid,
    input  xlen_t    fetch_pc,
    input  instr_t   fetch_instr,
    output logic     stall,
    output logic     issue_valid,
    output decoded_t issue
);

    decoded_t  id_dec;
    inflight_t ex_entry;
    inflight_t mem_entry;

    instr_decoder u_instr_decoder (
        .instr (fetch_instr),
        .pc    (fetch_pc),
        .dec   (id_dec)
    );

    hazard_stall u_hazard_stall (
        .fetch_valid (fetch_valid),
        .id_dec      (id_dec),
        .ex_entry    (ex_entry),
        .mem_entry   (mem_entry),
        .stall       (stall)
    );

    inflight_tracker u_inflight_tracker (
        .clk         (clk),
        .rst_n       (rst_n),
        .fetch_valid (fetch_valid),
        .stall       (stall),
        .id_dec      (id_dec),
        .ex_entry    (ex_entry),
        .mem_entry   (mem_entry)
    );

    // the issued packet is whatever sits in ex.
    assign issue_valid = ex_entry.valid;
    assign issue       = ex_entry.dec;

endmodule

`default_nettype wire

// File: verilog/inflight_tracker.sv
`default_nettype none

module inflight_tracker
    import pipe_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      fetch_valid,
    input  logic      stall,
    input  decoded_t  id_dec,
    output inflight_t ex_entry,
    output inflight_t mem_entry
);

    logic     consume;

    logic     ex_valid;
    logic     mem_valid;
    decoded_t ex_dec;
    decoded_t mem_dec;

    // the id slot moves on only when it holds something and is not held.
    assign consume = fetch_valid && !stall;

    // occupancy of the two stages.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
        end else begin
            // ex gets a bubble whenever nothing was consumed.
            ex_valid  <= consume;
            mem_valid <= ex_valid;
        end
    end

    // instruction payload, only meaningful where the matching valid is set.
    always_ff @(posedge clk) begin
        if (consume) begin
            ex_dec <= id_dec;
        end
        mem_dec <= ex_dec;
    end

    assign ex_entry.valid  = ex_valid;
    assign ex_entry.dec    = ex_dec;
    assign mem_entry.valid = mem_valid;
    assign mem_entry.dec   = mem_dec;

endmodule

`default_nettype wire

// File: verilog/instr_decoder.sv
`default_nettype none

module instr_decoder
    import rv_isa_pkg::*;
    import pipe_pkg::*;
(
    input  instr_t   instr,
    input  xlen_t    pc,
    output decoded_t dec
);

    opcode_t   opcode;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;

    logic      use_rs1;
    logic      use_rs2;
    logic      has_rd;
    logic      is_load;

    // the fields sit at the same place in every format.
    assign opcode = instr[opcode_lsb +: opcode_w];
    assign rs1    = instr[rs1_lsb +: reg_addr_w];
    assign rs2    = instr[rs2_lsb +: reg_addr_w];
    assign rd     = instr[rd_lsb +: reg_addr_w];

    // per-format use of the register fields.
    always_comb begin
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        has_rd  = 1'b0;
        is_load = 1'b0;

        case (opcode)
            // r-type.
            opc_op, opc_op_32: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
                has_rd  = 1'b1;
            end
            // i-type arithmetic and jalr.
            opc_op_imm, opc_op_imm_32, opc_jalr: begin
                use_rs1 = 1'b1;
                has_rd  = 1'b1;
            end
            opc_load: begin
                use_rs1 = 1'b1;
                has_rd  = 1'b1;
                is_load = 1'b1;
            end
            // s-type and b-type read both sources and write nothing.
            opc_store, opc_branch: begin
                use_rs1 = 1'b1;
                use_rs2 = 1'b1;
            end
            // u-type and j-type, the rs fields hold immediate bits.
            opc_lui, opc_auipc, opc_jal: begin
                has_rd = 1'b1;
            end
            default: begin
                // unknown opcode, treated as touching no register.
                use_rs1 = 1'b0;
            end
        endcase
    end

    always_comb begin
        dec.pc      = pc;
        dec.instr   = instr;
        dec.rs1     = rs1;
        dec.rs2     = rs2;
        dec.rd      = rd;
        dec.use_rs1 = use_rs1;
        dec.use_rs2 = use_rs2;

        // a write to x0 is discarded, so it never blocks anyone.
        if (!has_rd || rd == reg_zero) begin
            dec.writer = wr_none;
        end else if (is_load) begin
            dec.writer = wr_load;
        end else begin
            dec.writer = wr_alu;
        end
    end

endmodule

`default_nettype wire

// File: verilog/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

    import rv_isa_pkg::*;

    // what an in-flight instruction will write back.
    // wr_none must stay at zero so a cleared entry reads as no writer.
    typedef enum logic [1:0] {
        wr_none = 2'd0,
        wr_alu  = 2'd1,
        wr_load = 2'd2
    } writer_class_e;

    // one instruction after decode.
    // rs1, rs2 and rd are the raw fields; the use flags and the writer
    // class tell which of them are meaningful for the format.
    typedef struct packed {
        xlen_t         pc;
        instr_t        instr;
        reg_addr_t     rs1;
        reg_addr_t     rs2;
        reg_addr_t     rd;
        logic          use_rs1;
        logic          use_rs2;
        writer_class_e writer;
    } decoded_t;

    // one pipeline stage slot, a bubble when valid is low.
    typedef struct packed {
        logic     valid;
        decoded_t dec;
    } inflight_t;

endpackage

`default_nettype wire

// File: verilog/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // base widths of rv64i.
    localparam int unsigned xlen       = 64;
    localparam int unsigned ilen       = 32;
    localparam int unsigned reg_addr_w = 5;
    localparam int unsigned opcode_w   = 7;

    typedef logic [xlen-1:0]       xlen_t;
    typedef logic [ilen-1:0]       instr_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;
    typedef logic [opcode_w-1:0]   opcode_t;

    // field positions, identical in every format that carries the field.
    localparam int unsigned opcode_lsb = 0;
    localparam int unsigned rd_lsb     = 7;
    localparam int unsigned rs1_lsb    = 15;
    localparam int unsigned rs2_lsb    = 20;

    // x0 reads as zero and ignores writes.
    localparam reg_addr_t reg_zero = '0;

    // major opcodes, register-register and immediate arithmetic.
    localparam opcode_t opc_op        = 7'b0110011;
    localparam opcode_t opc_op_imm    = 7'b0010011;
    localparam opcode_t opc_op_32     = 7'b0111011;
    localparam opcode_t opc_op_imm_32 = 7'b0011011;

    // memory access.
    localparam opcode_t opc_load  = 7'b0000011;
    localparam opcode_t opc_store = 7'b0100011;

    // control transfer.
    localparam opcode_t opc_branch = 7'b1100011;
    localparam opcode_t opc_jal    = 7'b1101111;
    localparam opcode_t opc_jalr   = 7'b1100111;

    // upper immediates.
    localparam opcode_t opc_lui   = 7'b0110111;
    localparam opcode_t opc_auipc = 7'b0010111;

endpackage

`default_nettype wire
